// ==== verilog.f ====
+incdir+rtl
rtl/axi_wr_pkg.sv
rtl/burst_addr_if.sv
rtl/sync_fifo.sv
rtl/burst_addr_gen.sv
rtl/wr_burst_ctrl.sv
rtl/axi_wr_slave.sv
verification/tb_axi_wr_slave.sv

// ==== Bender.yml ====
package:
  name: axi_wr_slave

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axi_wr_pkg.sv
      - rtl/burst_addr_if.sv
      - rtl/sync_fifo.sv
      - rtl/burst_addr_gen.sv
      - rtl/wr_burst_ctrl.sv
      - rtl/axi_wr_slave.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/tb_axi_wr_slave.sv

// ==== verification/tb_axi_wr_slave.sv ====
// Testbench for the AXI4 write slave with AXI master driver, reference model and checker
`include "axi_wr_settings.svh"

module tb_axi_wr_slave;

    // Expected view of one memory beat
    typedef struct packed {
        logic                   err;
        logic [`AXI_STRB_W-1:0] strb;
        logic [`AXI_ADDR_W-1:0] addr;
    } beat_exp_t;

    localparam int wait_limit = 2000;

    logic                    clk;
    logic                    rst_n;
    logic [`AXI_ID_W-1:0]    awid;
    logic [`AXI_ADDR_W-1:0]  awaddr;
    logic [`AXI_LEN_W-1:0]   awlen;
    logic [`AXI_SIZE_W-1:0]  awsize;
    logic [`AXI_BURST_W-1:0] awburst;
    logic                    awvalid;
    logic                    awready;
    logic [`AXI_DATA_W-1:0]  wdata;
    logic [`AXI_STRB_W-1:0]  wstrb;
    logic                    wlast;
    logic                    wvalid;
    logic                    wready;
    logic [`AXI_ID_W-1:0]    bid;
    logic [`AXI_RESP_W-1:0]  bresp;
    logic                    bvalid;
    logic                    bready;
    logic                    mem_ready;
    logic [`AXI_ADDR_W-1:0]  mem_addr;
    logic [`AXI_DATA_W-1:0]  mem_data;
    logic [`AXI_STRB_W-1:0]  mem_strb;
    logic                    mem_last;
    logic                    mem_we;
    logic                    boundary_err;

    integer      seed;
    logic        random_bp;
    logic [31:0] bp_rnd;

    // ------------------------------------------------------------------
    // Queues
    // ------------------------------------------------------------------
    // Commands waiting for their AW handshake
    logic [`AXI_ID_W-1:0]    txn_id_q[$];
    logic [`AXI_ADDR_W-1:0]  txn_addr_q[$];
    logic [`AXI_LEN_W-1:0]   txn_len_q[$];
    logic [`AXI_SIZE_W-1:0]  txn_size_q[$];
    logic [`AXI_BURST_W-1:0] txn_burst_q[$];
    // W beats still to be driven
    logic [`AXI_DATA_W-1:0]  drv_data_q[$];
    logic [`AXI_STRB_W-1:0]  drv_strb_q[$];
    logic                    drv_last_q[$];
    // Memory beats still expected in issue order
    beat_exp_t               exp_beat_q[$];
    logic [`AXI_DATA_W-1:0]  exp_data_q[$];
    logic                    exp_last_q[$];
    int                      exp_test_q[$];
    // Responses still expected
    logic [`AXI_ID_W-1:0]    exp_bid_q[$];
    logic [`AXI_RESP_W-1:0]  exp_bresp_q[$];
    int                      exp_btest_q[$];

    axi_wr_slave dut_i (
        .clk(clk), .rst_n(rst_n),
        .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
        .awburst(awburst), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_data(mem_data),
        .mem_strb(mem_strb), .mem_last(mem_last), .mem_we(mem_we),
        .boundary_err(boundary_err)
    );

    always #5 clk = ~clk;

    // Random stalls on the memory port and on BREADY
    always @(posedge clk) begin
        #1;
        if (random_bp) begin
            bp_rnd = $random(seed);
            mem_ready = (bp_rnd[1:0] != 2'b00);
            bready    = (bp_rnd[5:4] != 2'b00);
        end else begin
            mem_ready = 1'b1;
            bready    = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    // Address, lane strobe and boundary flag of beat k of a burst
    function automatic beat_exp_t model_beat(input logic [31:0] addr, input logic [2:0] size,
                                             input logic [1:0] burst, input logic [7:0] len,
                                             input int k);
        beat_exp_t   e;
        logic [31:0] r;
        logic [31:0] step;
        logic [31:0] nxt;
        int          i;
        int          bytes;
        int          lo;
        int          hi;
        step = (burst == axi_wr_pkg::BURST_FIXED) ? 32'd0 : (32'd1 << size);
        // Later beats step from the aligned start
        r = addr & ({32{1'b1}} << size);
        e.addr = addr;
        for (i = 1; i <= k; i++) begin
            nxt = r + step;
            // Stay inside the 4 KB page
            if (nxt[`BOUNDARY_BIT] == r[`BOUNDARY_BIT]) begin
                r = nxt;
            end
            e.addr = r;
        end
        nxt = r + step;
        e.err = (k < len) && (nxt[`BOUNDARY_BIT] != r[`BOUNDARY_BIT]);
        if (size > 3'd2) begin
            e.strb = 4'hf;
        end else begin
            // Lanes from the beat address up to the end of its container
            bytes = 1 << size;
            lo = e.addr[1:0];
            hi = (lo / bytes) * bytes + bytes - 1;
            for (i = 0; i < 4; i++) begin
                e.strb[i] = (i >= lo) && (i <= hi);
            end
        end
        return e;
    endfunction

    // Oversized transfers are answered with SLVERR
    function automatic logic [1:0] model_resp(input logic [2:0] size);
        return (size > 3'd2) ? axi_wr_pkg::RESP_SLVERR : axi_wr_pkg::RESP_OKAY;
    endfunction

    function automatic string test_label(input int n);
        case (n)
            1: return "single_beat";
            2: return "incr_narrow_unaligned";
            3: return "fixed_burst";
            4: return "oversized_slverr";
            5: return "boundary_4k";
            default: return "outstanding_backpressure";
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Error reporting
    // ------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("ERROR %s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s %s expected %h actual %h", test, what, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    // ------------------------------------------------------------------
    // AXI master driver
    // ------------------------------------------------------------------
    // Queue one transaction with its W beats and expectations
    task automatic record_txn(input int test, input logic [3:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [2:0] size,
                              input logic [1:0] burst);
        beat_exp_t   e;
        logic [31:0] d;
        int          k;
        txn_id_q.push_back(id);
        txn_addr_q.push_back(addr);
        txn_len_q.push_back(len);
        txn_size_q.push_back(size);
        txn_burst_q.push_back(burst);
        for (k = 0; k <= len; k++) begin
            e = model_beat(addr, size, burst, len, k);
            d = $random(seed);
            drv_data_q.push_back(d);
            drv_strb_q.push_back(e.strb);
            drv_last_q.push_back(k == len);
            exp_beat_q.push_back(e);
            exp_data_q.push_back(d);
            exp_last_q.push_back(k == len);
            exp_test_q.push_back(test);
        end
        exp_bid_q.push_back(id);
        exp_bresp_q.push_back(model_resp(size));
        exp_btest_q.push_back(test);
    endtask

    task automatic drive_aw_all();
        int waited;
        while (txn_id_q.size() != 0) begin
            awid    = txn_id_q.pop_front();
            awaddr  = txn_addr_q.pop_front();
            awlen   = txn_len_q.pop_front();
            awsize  = txn_size_q.pop_front();
            awburst = txn_burst_q.pop_front();
            awvalid = 1'b1;
            waited  = 0;
            // AWREADY settles by the falling edge
            @(negedge clk);
            while (!awready) begin
                waited++;
                if (waited > wait_limit) begin
                    abort_run("timeout waiting for AWREADY");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        awvalid = 1'b0;
    endtask

    task automatic drive_w_all();
        int waited;
        while (drv_data_q.size() != 0) begin
            wdata  = drv_data_q.pop_front();
            wstrb  = drv_strb_q.pop_front();
            wlast  = drv_last_q.pop_front();
            wvalid = 1'b1;
            waited = 0;
            @(negedge clk);
            while (!wready) begin
                waited++;
                if (waited > wait_limit) begin
                    abort_run("timeout waiting for WREADY");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    // Until every expected beat and response has been seen
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_beat_q.size() != 0 || exp_bid_q.size() != 0) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout waiting for the DUT to finish its beats and responses");
            end
            @(posedge clk);
        end
        #1;
    endtask

    task automatic run_txn(input int test, input logic [3:0] id, input logic [31:0] addr,
                           input logic [7:0] len, input logic [2:0] size,
                           input logic [1:0] burst);
        record_txn(test, id, addr, len, size, burst);
        drive_aw_all();
        drive_w_all();
        wait_drain();
    endtask

    // ------------------------------------------------------------------
    // Checker
    // ------------------------------------------------------------------
    task automatic check_beat();
        beat_exp_t   e;
        logic [31:0] d;
        logic        l;
        string       t;
        if (exp_beat_q.size() == 0) begin
            abort_run("memory write seen with no beat left to expect");
        end else begin
            e = exp_beat_q.pop_front();
            d = exp_data_q.pop_front();
            l = exp_last_q.pop_front();
            t = test_label(exp_test_q.pop_front());
            assert (mem_addr == e.addr) else report_mismatch(t, "mem_addr", e.addr, mem_addr);
            assert (mem_data == d) else report_mismatch(t, "mem_data", d, mem_data);
            assert (mem_strb == e.strb)
                else report_mismatch(t, "mem_strb", 32'(e.strb), 32'(mem_strb));
            assert (mem_last == l) else report_mismatch(t, "mem_last", 32'(l), 32'(mem_last));
            assert (boundary_err == e.err)
                else report_mismatch(t, "boundary_err", 32'(e.err), 32'(boundary_err));
        end
    endtask

    task automatic check_rsp();
        logic [3:0] id;
        logic [1:0] rsp;
        string      t;
        if (exp_bid_q.size() == 0) begin
            abort_run("write response seen with no transaction outstanding");
        end else begin
            id  = exp_bid_q.pop_front();
            rsp = exp_bresp_q.pop_front();
            t   = test_label(exp_btest_q.pop_front());
            assert (bid == id) else report_mismatch(t, "bid", 32'(id), 32'(bid));
            assert (bresp == rsp) else report_mismatch(t, "bresp", 32'(rsp), 32'(bresp));
        end
    endtask

    // Outputs sampled on the falling edge while inputs move after the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_we) begin
                assert (mem_ready)
                    else abort_run("memory write issued while mem_ready was low");
                check_beat();
            end else begin
                assert (mem_strb == '0 && !mem_last && !boundary_err)
                    else abort_run("memory strobe, last or boundary flag active without a write");
            end
            if (bvalid && bready) begin
                check_rsp();
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        int          i;
        logic [31:0] rnd;
        seed       = 32'hd59fa0bc;
        random_bp  = 1'b0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        awid       = '0;
        awaddr     = '0;
        awlen      = '0;
        awsize     = '0;
        awburst    = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wlast      = 1'b0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        mem_ready  = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        run_txn(1, 4'h3, 32'h0000_0100, 8'd0, 3'd2, axi_wr_pkg::BURST_INCR);
        // Halfword burst from an odd byte
        run_txn(2, 4'h5, 32'h0000_0203, 8'd3, 3'd1, axi_wr_pkg::BURST_INCR);
        run_txn(3, 4'h7, 32'h0000_0340, 8'd3, 3'd2, axi_wr_pkg::BURST_FIXED);
        // Eight byte beats on a four byte bus
        run_txn(4, 4'h9, 32'h0000_2000, 8'd2, 3'd3, axi_wr_pkg::BURST_INCR);
        // Third beat would land on the next page
        run_txn(5, 4'ha, 32'h0000_0ff8, 8'd3, 3'd2, axi_wr_pkg::BURST_INCR);

        // Four commands in flight under random stalls
        random_bp = 1'b1;
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            record_txn(6, rnd[3:0], {18'd0, rnd[13:4], 4'd0} + 32'(rnd[15:14]),
                       {6'd0, rnd[17:16]}, (rnd[19:18] == 2'd3) ? 3'd2 : 3'(rnd[19:18]),
                       rnd[20] ? axi_wr_pkg::BURST_INCR : axi_wr_pkg::BURST_FIXED);
        end
        drive_aw_all();
        // All four commands wait in the AW FIFO until W data arrives
        assert (!awready)
            else abort_run("AWREADY still high with four commands buffered");
        drive_w_all();
        wait_drain();
        random_bp = 1'b0;

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== rtl/axi_wr_slave.sv ====
// AXI4 write slave: buffers AW, W and B and writes bursts beat by beat to memory
`include "axi_wr_settings.svh"

module axi_wr_slave (
    input  logic                    clk,
    input  logic                    rst_n,
    // ------------------------------------------------------------------
    // AXI4 write address channel
    // ------------------------------------------------------------------
    input  logic [`AXI_ID_W-1:0]    awid,
    input  logic [`AXI_ADDR_W-1:0]  awaddr,
    input  logic [`AXI_LEN_W-1:0]   awlen,
    input  logic [`AXI_SIZE_W-1:0]  awsize,
    input  logic [`AXI_BURST_W-1:0] awburst,
    input  logic                    awvalid,
    output logic                    awready,
    // Write data channel
    input  logic [`AXI_DATA_W-1:0]  wdata,
    input  logic [`AXI_STRB_W-1:0]  wstrb,
    input  logic                    wlast,
    input  logic                    wvalid,
    output logic                    wready,
    // Write response channel
    output logic [`AXI_ID_W-1:0]    bid,
    output logic [`AXI_RESP_W-1:0]  bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // ------------------------------------------------------------------
    // Memory write port
    // ------------------------------------------------------------------
    input  logic                    mem_ready,
    output logic [`AXI_ADDR_W-1:0]  mem_addr,
    output logic [`AXI_DATA_W-1:0]  mem_data,
    output logic [`AXI_STRB_W-1:0]  mem_strb,
    output logic                    mem_last,
    output logic                    mem_we,
    // Burst tried to leave its 4 KB page
    output logic                    boundary_err
);

    axi_wr_pkg::aw_cmd_t aw_din;
    axi_wr_pkg::aw_cmd_t aw_dout;
    axi_wr_pkg::w_beat_t w_din;
    axi_wr_pkg::w_beat_t w_dout;
    axi_wr_pkg::b_rsp_t  b_din;
    axi_wr_pkg::b_rsp_t  b_dout;

    logic aw_push, aw_full, aw_pop, aw_empty;
    logic w_push, w_full, w_pop, w_empty;
    logic b_push, b_full, b_pop, b_empty;

    burst_addr_if addr_if ();

    // Channel packing
    assign aw_din.id    = awid;
    assign aw_din.addr  = awaddr;
    assign aw_din.len   = awlen;
    assign aw_din.size  = awsize;
    assign aw_din.burst = axi_wr_pkg::burst_e'(awburst);

    assign w_din.data = wdata;
    assign w_din.strb = wstrb;
    assign w_din.last = wlast;

    // Handshakes straight from the FIFO flags
    assign awready = !aw_full;
    assign aw_push = awvalid && awready;
    assign wready  = !w_full;
    assign w_push  = wvalid && wready;
    assign bvalid  = !b_empty;
    assign b_pop   = bvalid && bready;

    assign bid   = b_dout.id;
    assign bresp = b_dout.resp;

    // Outstanding commands
    sync_fifo #(.payload_t(axi_wr_pkg::aw_cmd_t), .depth(`AW_DEPTH)) aw_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(aw_push), .din(aw_din), .full(aw_full),
        .pop(aw_pop), .dout(aw_dout), .empty(aw_empty)
    );

    sync_fifo #(.payload_t(axi_wr_pkg::w_beat_t), .depth(`W_DEPTH)) w_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(w_push), .din(w_din), .full(w_full),
        .pop(w_pop), .dout(w_dout), .empty(w_empty)
    );

    // Responses leave in issue order
    sync_fifo #(.payload_t(axi_wr_pkg::b_rsp_t), .depth(`B_DEPTH)) b_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(b_push), .din(b_din), .full(b_full),
        .pop(b_pop), .dout(b_dout), .empty(b_empty)
    );

    wr_burst_ctrl ctrl_i (
        .clk(clk), .rst_n(rst_n),
        .aw_cmd(aw_dout), .aw_empty(aw_empty), .aw_pop(aw_pop),
        .w_beat(w_dout), .w_empty(w_empty), .w_pop(w_pop),
        .b_full(b_full), .b_push(b_push), .b_data(b_din),
        .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_data(mem_data),
        .mem_strb(mem_strb), .mem_last(mem_last), .mem_we(mem_we),
        .addr(addr_if.ctrl)
    );

    burst_addr_gen addr_gen_i (
        .clk(clk), .rst_n(rst_n),
        .addr(addr_if.gen),
        .boundary_err(boundary_err)
    );

endmodule

// ==== rtl/wr_burst_ctrl.sv ====
// Write burst controller: pairs commands with data beats and issues responses
`include "axi_wr_settings.svh"

module wr_burst_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    // AW FIFO read side
    input  axi_wr_pkg::aw_cmd_t    aw_cmd,
    input  logic                   aw_empty,
    output logic                   aw_pop,
    // W FIFO read side
    input  axi_wr_pkg::w_beat_t    w_beat,
    input  logic                   w_empty,
    output logic                   w_pop,
    // B FIFO write side
    input  logic                   b_full,
    output logic                   b_push,
    output axi_wr_pkg::b_rsp_t     b_data,
    // Memory write port
    input  logic                   mem_ready,
    output logic [`AXI_ADDR_W-1:0] mem_addr,
    output logic [`AXI_DATA_W-1:0] mem_data,
    output logic [`AXI_STRB_W-1:0] mem_strb,
    output logic                   mem_last,
    output logic                   mem_we,
    // Address generator
    burst_addr_if.ctrl             addr
);

    // Largest legal AWSIZE is log2 of the bus width in bytes
    localparam logic [`AXI_SIZE_W-1:0] size_max = `AXI_SIZE_W'($clog2(`AXI_DATA_W / 8));

    axi_wr_pkg::phase_e  phase_q;
    axi_wr_pkg::phase_e  phase_d;
    // Command of the burst in progress
    axi_wr_pkg::aw_cmd_t cmd_q;
    axi_wr_pkg::aw_cmd_t cur_cmd;
    logic                beat_go;
    logic                last_beat;
    logic                size_err;

    // FIFO head is the command on the first beat, the latch afterwards
    assign cur_cmd = (phase_q == axi_wr_pkg::PH_FIRST) ? aw_cmd : cmd_q;

    // ------------------------------------------------------------------
    // Beat issue
    // ------------------------------------------------------------------
    always_comb begin
        case (phase_q)
            // Needs both FIFO heads and a ready memory
            axi_wr_pkg::PH_FIRST: beat_go = !aw_empty && !w_empty && mem_ready;
            axi_wr_pkg::PH_BURST: beat_go = !w_empty && mem_ready;
            default:              beat_go = 1'b0;
        endcase
    end

    // Burst end comes from the beat count, WLAST is not trusted for it
    assign last_beat = beat_go && addr.beat_last;

    assign aw_pop = beat_go && (phase_q == axi_wr_pkg::PH_FIRST);
    assign w_pop  = beat_go;

    assign addr.start   = aw_pop;
    assign addr.advance = beat_go && (phase_q == axi_wr_pkg::PH_BURST);
    assign addr.cmd     = cur_cmd;
    assign addr.phase   = phase_q;

    // Memory port, strobe and last are quiet between beats
    assign mem_we   = beat_go;
    assign mem_addr = addr.beat_addr;
    assign mem_data = w_beat.data;
    assign mem_strb = beat_go ? w_beat.strb : '0;
    assign mem_last = beat_go ? w_beat.last : 1'b0;

    // ------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------
    assign size_err = (cur_cmd.size > size_max);

    // Push on the last beat, or later from BRESP once there is room
    assign b_push = !b_full && (last_beat || (phase_q == axi_wr_pkg::PH_BRESP));

    assign b_data.id   = cur_cmd.id;
    assign b_data.resp = size_err ? axi_wr_pkg::RESP_SLVERR : axi_wr_pkg::RESP_OKAY;

    // ------------------------------------------------------------------
    // Phase FSM
    // ------------------------------------------------------------------
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            axi_wr_pkg::PH_IDLE: begin
                phase_d = axi_wr_pkg::PH_FIRST;
            end
            axi_wr_pkg::PH_FIRST: begin
                if (beat_go) begin
                    if (!addr.beat_last) begin
                        phase_d = axi_wr_pkg::PH_BURST;
                    end else if (b_full) begin
                        phase_d = axi_wr_pkg::PH_BRESP;
                    end
                end
            end
            axi_wr_pkg::PH_BURST: begin
                if (last_beat) begin
                    phase_d = b_full ? axi_wr_pkg::PH_BRESP : axi_wr_pkg::PH_FIRST;
                end
            end
            axi_wr_pkg::PH_BRESP: begin
                // No new command until the response is stored
                if (!b_full) begin
                    phase_d = axi_wr_pkg::PH_FIRST;
                end
            end
            default: begin
                phase_d = axi_wr_pkg::PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= axi_wr_pkg::PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    // Latch the command as it leaves the AW FIFO
    always_ff @(posedge clk) begin
        if (aw_pop) begin
            cmd_q <= aw_cmd;
        end
    end

endmodule

// ==== rtl/burst_addr_gen.sv ====
// Burst address generator: beat addresses, beat count and 4 KB bounding
`include "axi_wr_settings.svh"

module burst_addr_gen (
    input  logic             clk,
    input  logic             rst_n,
    burst_addr_if.gen        addr,
    output logic             boundary_err
);

    localparam int addr_w = `AXI_ADDR_W;

    // Running address of the next non-first beat
    logic [`AXI_ADDR_W-1:0] run_addr;
    logic [`AXI_LEN_W-1:0]  beat_cnt;
    logic [`AXI_ADDR_W-1:0] aligned_addr;
    logic [`AXI_ADDR_W-1:0] addr_inc;
    logic [`AXI_ADDR_W-1:0] base_addr;
    logic [`AXI_ADDR_W-1:0] next_addr;
    logic                   first_beat;
    logic                   crosses;

    assign first_beat = (addr.phase == axi_wr_pkg::PH_FIRST);

    // ------------------------------------------------------------------
    // Address arithmetic
    // ------------------------------------------------------------------
    // Start address rounded down to the transfer size
    assign aligned_addr = addr.cmd.addr & ({addr_w{1'b1}} << addr.cmd.size);

    // FIXED repeats its address, every other burst type steps by size
    assign addr_inc = (addr.cmd.burst == axi_wr_pkg::BURST_FIXED) ?
                      '0 : (addr_w'(1) << addr.cmd.size);

    // Second beat steps from the aligned start, later ones from run_addr
    assign base_addr = first_beat ? aligned_addr : run_addr;
    assign next_addr = base_addr + addr_inc;

    // Page bit would flip on the next beat
    assign crosses = (next_addr[`BOUNDARY_BIT] != base_addr[`BOUNDARY_BIT]);

    // ------------------------------------------------------------------
    // Beat outputs
    // ------------------------------------------------------------------
    // First beat keeps the unaligned address as given on AW
    assign addr.beat_addr = first_beat ? addr.cmd.addr : run_addr;

    // AWLEN counts beats minus one
    assign addr.beat_last = first_beat ? (addr.cmd.len == '0) :
                                         (beat_cnt == addr.cmd.len);

    // Only a beat with a successor can run off the page
    assign addr.cross_err = (addr.start || addr.advance) && crosses &&
                            !addr.beat_last;

    assign boundary_err = addr.cross_err;

    // ------------------------------------------------------------------
    // Running address and beat counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_addr <= '0;
            beat_cnt <= '0;
        end else if (addr.start) begin
            beat_cnt <= `AXI_LEN_W'(1);
            // Hold inside the page instead of stepping over the boundary
            run_addr <= crosses ? base_addr : next_addr;
        end else if (addr.advance) begin
            beat_cnt <= beat_cnt + 1'b1;
            run_addr <= crosses ? base_addr : next_addr;
        end
    end

endmodule

// ==== rtl/sync_fifo.sv ====
// Synchronous show-ahead FIFO with a typed payload
module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);
    localparam logic [cnt_w-1:0] full_cnt  = cnt_w'(depth);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Requests against a full or empty FIFO are dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == full_cnt);
    assign empty = (count == '0);

    // Head entry is always on the output
    assign dout = mem[rd_ptr];

    // ------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // Wrap explicitly, depth need not be a power of two
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== rtl/burst_addr_if.sv ====
// Link between the burst controller and the burst address generator
`include "axi_wr_settings.svh"

interface burst_addr_if;

    // Controller side
    // First beat of a burst, cmd is valid with it
    logic                   start;
    // Any later accepted beat
    logic                   advance;
    // Current command, FIFO head on the first beat, latched copy after
    axi_wr_pkg::aw_cmd_t    cmd;
    axi_wr_pkg::phase_e     phase;

    // Generator side
    logic [`AXI_ADDR_W-1:0] beat_addr;
    // Beat in flight is the last of its burst
    logic                   beat_last;
    // Next address would leave the 4 KB page
    logic                   cross_err;

    modport ctrl (
        output start,
        output advance,
        output cmd,
        output phase,
        input  beat_addr,
        input  beat_last,
        input  cross_err
    );

    modport gen (
        input  start,
        input  advance,
        input  cmd,
        input  phase,
        output beat_addr,
        output beat_last,
        output cross_err
    );

endinterface

// ==== rtl/axi_wr_pkg.sv ====
// Shared types of the AXI4 write slave: channel payloads and FSM phases
`include "axi_wr_settings.svh"

package axi_wr_pkg;

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------
    // AWBURST values, WRAP and RESERVED run as INCR
    typedef enum logic [`AXI_BURST_W-1:0] {
        BURST_FIXED    = 2'b00,
        BURST_INCR     = 2'b01,
        BURST_WRAP     = 2'b10,
        BURST_RESERVED = 2'b11
    } burst_e;

    // BRESP values, only OKAY and SLVERR are ever produced
    typedef enum logic [`AXI_RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // Burst controller phases
    // FIRST issues the beat that pairs a command with data
    // BURST issues the remaining beats
    // BRESP waits for room in the response FIFO
    typedef enum logic [1:0] {
        PH_FIRST = 2'b00,
        PH_BURST = 2'b01,
        PH_BRESP = 2'b10,
        PH_IDLE  = 2'b11
    } phase_e;

    // ------------------------------------------------------------------
    // Channel payloads
    // ------------------------------------------------------------------
    // Write address command, 49 bits
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        logic [`AXI_SIZE_W-1:0] size;
        burst_e                 burst;
    } aw_cmd_t;

    // Write data beat, 37 bits
    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        logic                   last;
    } w_beat_t;

    // Write response, 6 bits
    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        resp_e                resp;
    } b_rsp_t;

endpackage

// ==== rtl/axi_wr_settings.svh ====
// AXI4 write slave settings: bus widths, FIFO depths and the 4 KB page bit
`ifndef AXI_WR_SETTINGS_SVH
`define AXI_WR_SETTINGS_SVH

// ----------------------------------------------------------------------
// AXI4 field widths
// ----------------------------------------------------------------------
`define AXI_DATA_W 32
`define AXI_ADDR_W 32
`define AXI_ID_W 4
`define AXI_LEN_W 8
`define AXI_SIZE_W 3
`define AXI_BURST_W 2
`define AXI_RESP_W 2

// One strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// ----------------------------------------------------------------------
// Buffering
// ----------------------------------------------------------------------
// Outstanding write commands
`define AW_DEPTH 4
// Write data beats
`define W_DEPTH 16
// Pending write responses
`define B_DEPTH 4

// Address bit that toggles when a burst leaves its 4 KB page
`define BOUNDARY_BIT 12

`endif
